/* hw/eeprom_pkg.sv */
package eeprom_pkg;

    // ******************************
    // storage geometry
    // ******************************

    localparam int mem_addr_width = 11;                // page bits 10:8 plus address byte.
    localparam int mem_depth = 2048;

    // ******************************
    // bus addressing
    // ******************************

    localparam logic [3:0] device_code = 4'b1010;      // upper nibble of every control byte.

    // ******************************
    // enums
    // ******************************

    // the bit engine reports each event as a one-cycle pulse.
    typedef enum logic [1:0] {
        evt_none,
        evt_start,
        evt_stop,
        evt_byte_done
    } bus_event_t;

    // command sequencer states.
    typedef enum logic [2:0] {
        st_idle,
        st_ctrl,
        st_addr,
        st_write_data,
        st_read_load,
        st_read_data,
        st_ignore
    } cmd_state_t;

endpackage

/* hw/i2c_byte_if.sv */
interface i2c_byte_if;
    import eeprom_pkg::*;

    bus_event_t  evt;         // start, stop or byte_done pulse.
    logic [7:0]  rx_byte;     // valid while evt is byte_done.
    logic        master_ack;  // low when the master acknowledged the last sent byte.
    logic        ack_en;      // acknowledge the byte being received.
    logic        tx_load;     // loads tx_byte into the transmit shifter.
    logic [7:0]  tx_byte;
    logic        tx_mode;     // the next byte is sent by the slave.

    modport engine (
        output evt,
        output rx_byte,
        output master_ack,
        input  ack_en,
        input  tx_load,
        input  tx_byte,
        input  tx_mode
    );

    modport seq (
        input  evt,
        input  rx_byte,
        input  master_ack,
        output ack_en,
        output tx_load,
        output tx_byte,
        output tx_mode
    );

endinterface

/* hw/mem_port_if.sv */
interface mem_port_if;
    import eeprom_pkg::*;

    logic                      we;     // single-cycle write strobe.
    logic                      re;     // single-cycle read strobe.
    logic [mem_addr_width-1:0] addr;
    logic [7:0]                wdata;
    logic [7:0]                rdata;  // valid the cycle after re.

    modport ctrl (
        output we,
        output re,
        output addr,
        output wdata,
        input  rdata
    );

    modport mem (
        input  we,
        input  re,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

/* hw/i2c_bit_engine.sv */
module i2c_bit_engine (
    input  logic      sda,
    input  logic      rst,
    input  logic      bus_scl,
    input  logic      bus_data,
    output logic      bus_data_oe,
    i2c_byte_if.engine byte_bus
);
    import eeprom_pkg::*;

    logic       scl_s1;
    logic       scl_s2;
    logic       scl_d;
    logic       data_s1;
    logic       data_s2;
    logic       data_d;
    logic       scl_rise;
    logic       scl_fall;
    logic       start_det;
    logic       stop_det;
    logic       active;
    logic [3:0] bit_cnt;
    logic       byte_is_tx;
    logic       tx_shift_en;
    logic [7:0] rx_shift;
    logic [7:0] tx_shift;

    // ******************************
    // synchronizers and edge detect
    // ******************************

    always_ff @(posedge sda)
    begin
        if (rst)
        begin
            scl_s1 <= 1'b1;                            // idle bus reads high.
            scl_s2 <= 1'b1;
            scl_d <= 1'b1;
            data_s1 <= 1'b1;
            data_s2 <= 1'b1;
            data_d <= 1'b1;
        end
        else
        begin
            scl_s1 <= bus_scl;
            scl_s2 <= scl_s1;
            scl_d <= scl_s2;
            data_s1 <= bus_data;
            data_s2 <= data_s1;
            data_d <= data_s2;
        end
    end

    assign scl_rise = scl_s2 && !scl_d;
    assign scl_fall = !scl_s2 && scl_d;
    assign start_det = scl_s2 && scl_d && data_d && !data_s2;  // data falls while scl high.
    assign stop_det = scl_s2 && scl_d && !data_d && data_s2;   // data rises while scl high.

    // ******************************
    // bit counter and line control
    // ******************************

    // bit_cnt counts the rises of a byte; slot 8 is the acknowledge clock.
    // A received byte completes on the eighth rise, a sent byte on the ninth,
    // once the master's acknowledge has been sampled.
    always_ff @(posedge sda)
    begin
        if (rst)
        begin
            active <= 1'b0;
            bit_cnt <= 4'd0;
            byte_is_tx <= 1'b0;
            bus_data_oe <= 1'b0;
            byte_bus.evt <= evt_none;
            byte_bus.master_ack <= 1'b1;
        end
        else
        begin
            byte_bus.evt <= evt_none;
            if (start_det)
            begin
                active <= 1'b1;
                bit_cnt <= 4'd0;                       // a partial byte is dropped.
                byte_is_tx <= 1'b0;
                bus_data_oe <= 1'b0;
                byte_bus.evt <= evt_start;
            end
            else if (stop_det)
            begin
                active <= 1'b0;
                bit_cnt <= 4'd0;
                byte_is_tx <= 1'b0;
                bus_data_oe <= 1'b0;
                byte_bus.evt <= evt_stop;
            end
            else if (active && scl_rise)
            begin
                if (bit_cnt == 4'd8)
                begin
                    bit_cnt <= 4'd0;
                    if (byte_is_tx)
                    begin
                        byte_bus.master_ack <= data_s2;
                        byte_bus.evt <= evt_byte_done;
                    end
                end
                else
                begin
                    bit_cnt <= bit_cnt + 4'd1;
                    if (bit_cnt == 4'd7 && !byte_is_tx)
                    begin
                        byte_bus.evt <= evt_byte_done;
                    end
                end
            end
            else if (active && scl_fall)
            begin
                if (bit_cnt == 4'd8)
                begin
                    bus_data_oe <= !byte_is_tx && byte_bus.ack_en;  // master owns a tx ack slot.
                end
                else if (bit_cnt == 4'd0)
                begin
                    byte_is_tx <= byte_bus.tx_mode;    // direction is fixed at the byte boundary.
                    bus_data_oe <= byte_bus.tx_mode && !tx_shift[7];
                end
                else
                begin
                    bus_data_oe <= byte_is_tx && !tx_shift[7];
                end
            end
        end
    end

    // ******************************
    // data shifters
    // ******************************

    assign tx_shift_en = (bit_cnt == 4'd0) ? byte_bus.tx_mode
                                           : (bit_cnt != 4'd8) && byte_is_tx;

    always_ff @(posedge sda)
    begin
        if (active && scl_rise && bit_cnt != 4'd8)
        begin
            rx_shift <= {rx_shift[6:0], data_s2};      // msb arrives first.
        end
    end

    always_ff @(posedge sda)
    begin
        if (active && scl_fall && tx_shift_en)
        begin
            tx_shift <= {tx_shift[6:0], 1'b0};
        end
        else if (byte_bus.tx_load)
        begin
            tx_shift <= byte_bus.tx_byte;
        end
    end

    assign byte_bus.rx_byte = rx_shift;

endmodule

/* hw/eeprom_cmd_fsm.sv */
module eeprom_cmd_fsm (
    input  logic    sda,
    input  logic    rst,
    i2c_byte_if.seq byte_bus,
    mem_port_if.ctrl mem
);
    import eeprom_pkg::*;

    cmd_state_t                state;
    logic [mem_addr_width-1:0] cur_addr;
    logic                      byte_done;
    logic                      ctrl_match;

    assign byte_done = (byte_bus.evt == evt_byte_done);
    assign ctrl_match = (byte_bus.rx_byte[7:4] == device_code);

    // ******************************
    // sequencer
    // ******************************

    always_ff @(posedge sda)
    begin
        if (rst)
        begin
            state <= st_idle;
            cur_addr <= '0;
            byte_bus.ack_en <= 1'b0;
            byte_bus.tx_load <= 1'b0;
        end
        else
        begin
            byte_bus.tx_load <= (state == st_read_load);  // rdata is valid now.
            if (byte_bus.evt == evt_start)
            begin
                state <= st_ctrl;
                byte_bus.ack_en <= 1'b0;
            end
            else if (byte_bus.evt == evt_stop)
            begin
                state <= st_idle;
                byte_bus.ack_en <= 1'b0;
            end
            else if (byte_done)
            begin
                case (state)
                    st_ctrl:
                    begin
                        byte_bus.ack_en <= ctrl_match;
                        if (!ctrl_match)
                        begin
                            state <= st_ignore;        // another device on the bus.
                        end
                        else
                        begin
                            cur_addr[10:8] <= byte_bus.rx_byte[3:1];
                            state <= byte_bus.rx_byte[0] ? st_read_load : st_addr;
                        end
                    end
                    st_addr:
                    begin
                        byte_bus.ack_en <= 1'b1;
                        cur_addr[7:0] <= byte_bus.rx_byte;
                        state <= st_write_data;
                    end
                    st_write_data:
                    begin
                        byte_bus.ack_en <= 1'b1;
                        cur_addr <= cur_addr + 1'b1;   // wraps from 2047 to 0.
                    end
                    st_read_data:
                    begin
                        byte_bus.ack_en <= 1'b0;
                        // a nack releases the bus until the next start.
                        state <= byte_bus.master_ack ? st_ignore : st_read_load;
                    end
                    default:
                    begin
                        byte_bus.ack_en <= 1'b0;
                    end
                endcase
            end
            else if (state == st_read_load)
            begin
                cur_addr <= cur_addr + 1'b1;
                state <= st_read_data;
            end
        end
    end

    // ******************************
    // engine and memory strobes
    // ******************************

    assign byte_bus.tx_mode = (state == st_read_load) || (state == st_read_data);
    assign byte_bus.tx_byte = mem.rdata;

    assign mem.we = (state == st_write_data) && byte_done;
    assign mem.re = (state == st_read_load);
    assign mem.addr = cur_addr;
    assign mem.wdata = byte_bus.rx_byte;

endmodule

/* hw/eeprom_array.sv */
module eeprom_array (
    input  logic   sda,
    mem_port_if.mem mem
);
    import eeprom_pkg::*;

    logic [7:0] storage [mem_depth];

    // a write and a read never share a cycle on this single port.
    always_ff @(posedge sda)
    begin
        if (mem.we)
        begin
            storage[mem.addr] <= mem.wdata;
        end
    end

    always_ff @(posedge sda)
    begin
        if (mem.re)
        begin
            mem.rdata <= storage[mem.addr];  // registered read data.
        end
    end

endmodule

/* hw/eeprom_top.sv */
module eeprom_top (
    input  logic sda,
    input  logic rst,
    input  logic bus_scl,
    input  logic bus_data,
    output logic bus_data_oe
);

    // ******************************
    // internal links
    // ******************************

    i2c_byte_if byte_bus ();
    mem_port_if mem_port ();

    // ******************************
    // blocks
    // ******************************

    // bit engine turns bus activity into byte events.
    i2c_bit_engine i2c_bit_engine_i (
        .sda         (sda),
        .rst         (rst),
        .bus_scl     (bus_scl),
        .bus_data    (bus_data),
        .bus_data_oe (bus_data_oe),
        .byte_bus    (byte_bus.engine)
    );

    eeprom_cmd_fsm eeprom_cmd_fsm_i (
        .sda      (sda),
        .rst      (rst),
        .byte_bus (byte_bus.seq),
        .mem      (mem_port.ctrl)
    );

    eeprom_array eeprom_array_i (
        .sda (sda),
        .mem (mem_port.mem)
    );

endmodule

/* tests/i2c_master_tasks.svh */
`ifndef i2c_master_tasks_svh
`define i2c_master_tasks_svh

// ******************************
// bus master
// ******************************

localparam int half_clks = 10;     // clocks per scl level.
localparam int quarter_clks = 5;   // data changes this far into a low phase.

task automatic wait_clks(input int n);
    repeat (n) @(posedge sda);
    #2;
endtask

task automatic bus_start();
    if (!bus_scl)
    begin
        wait_clks(quarter_clks);
        master_low = 1'b0;                     // release before scl rises.
        wait_clks(half_clks - quarter_clks);
        bus_scl = 1'b1;
        wait_clks(half_clks);
    end
    else
    begin
        master_low = 1'b0;
        wait_clks(half_clks);
    end
    master_low = 1'b1;                         // data falls while scl is high.
    wait_clks(half_clks);
    bus_scl = 1'b0;
endtask

task automatic bus_stop();
    wait_clks(quarter_clks);
    master_low = 1'b1;
    wait_clks(half_clks - quarter_clks);
    bus_scl = 1'b1;
    wait_clks(half_clks);
    master_low = 1'b0;                         // data rises while scl is high.
    wait_clks(half_clks);
endtask

task automatic send_bits(input logic [7:0] b, input int n);
    int i;
    for (i = 0; i < n; i++)
    begin
        wait_clks(quarter_clks);
        master_low = !b[7 - i];                // msb first.
        wait_clks(half_clks - quarter_clks);
        bus_scl = 1'b1;
        wait_clks(half_clks);
        bus_scl = 1'b0;
    end
endtask

task automatic send_byte(input logic [7:0] b, output logic acked);
    send_bits(b, 8);
    wait_clks(quarter_clks);
    master_low = 1'b0;
    wait_clks(half_clks - quarter_clks);
    bus_scl = 1'b1;
    wait_clks(quarter_clks);
    acked = !bus_data;                         // slave pulls low to acknowledge.
    wait_clks(half_clks - quarter_clks);
    bus_scl = 1'b0;
endtask

task automatic recv_byte(input logic ack, output logic [7:0] b);
    int i;
    for (i = 0; i < 8; i++)
    begin
        wait_clks(quarter_clks);
        master_low = 1'b0;
        wait_clks(half_clks - quarter_clks);
        bus_scl = 1'b1;
        wait_clks(quarter_clks);
        b = {b[6:0], bus_data};
        wait_clks(half_clks - quarter_clks);
        bus_scl = 1'b0;
    end
    wait_clks(quarter_clks);
    master_low = ack;                          // a high line here is a nack.
    wait_clks(half_clks - quarter_clks);
    bus_scl = 1'b1;
    wait_clks(half_clks);
    bus_scl = 1'b0;
endtask

`endif

/* tests/tb_eeprom_top.sv */
module tb_eeprom_top;
    import eeprom_pkg::*;

    localparam int max_cycles = 200000;  // about six times the ~32000 clocks the sequence takes.

    logic        sda = 1'b0;
    logic        rst = 1'b1;
    logic        bus_scl = 1'b1;
    logic        master_low = 1'b0;
    logic        bus_data;
    logic        bus_data_oe;

    logic [7:0]  ref_mem [mem_depth];
    logic [10:0] model_addr;
    logic [7:0]  wr_buf [16];
    logic [7:0]  got_byte;
    logic [10:0] got_addr;
    logic [7:0]  exp_byte;
    event        byte_received;
    int          checks = 0;
    int          errors = 0;
    int          cycles = 0;
    int          seed = 28;
    logic [10:0] wr_start [$];
    int          wr_len [$];

    // the pulled-up line is low when either side drives it.
    assign bus_data = !(master_low || bus_data_oe);

    always #10 sda = ~sda;

    eeprom_top eeprom_top_i (
        .sda         (sda),
        .rst         (rst),
        .bus_scl     (bus_scl),
        .bus_data    (bus_data),
        .bus_data_oe (bus_data_oe)
    );

    `include "i2c_master_tasks.svh"

    // ******************************
    // reference model and compare
    // ******************************

    function automatic logic [7:0] expected_read(input logic [10:0] addr);
        return ref_mem[addr];
    endfunction

    function automatic logic [7:0] ctrl_byte(input logic [2:0] page, input logic rd);
        return {device_code, page, rd};
    endfunction

    always @(byte_received)
    begin
        exp_byte = expected_read(got_addr);
        checks++;
        if (got_byte !== exp_byte)
        begin
            errors++;
            $display("MISMATCH at %0t: read 0x%h from 0x%h, expected 0x%h",
                     $time, got_byte, got_addr, exp_byte);
        end
    end

    always @(posedge sda)
    begin
        cycles++;
        if (cycles >= max_cycles)
        begin
            $display("timeout: the run did not finish within %0d clocks", max_cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    // ******************************
    // transfers
    // ******************************

    task automatic expect_ack(input logic acked, input string what);
        checks++;
        if (!acked)
        begin
            errors++;
            $display("ERROR at %0t: the slave gave no acknowledge for the %s", $time, what);
        end
    endtask

    task automatic set_address(input logic [10:0] addr);
        logic acked;
        bus_start();
        send_byte(ctrl_byte(addr[10:8], 1'b0), acked);
        expect_ack(acked, "write control byte");
        send_byte(addr[7:0], acked);
        expect_ack(acked, "address byte");
        model_addr = addr;
    endtask

    task automatic write_data(input int count);
        logic acked;
        int i;
        for (i = 0; i < count; i++)
        begin
            send_byte(wr_buf[i], acked);
            expect_ack(acked, "write data byte");
            ref_mem[model_addr] = wr_buf[i];
            model_addr = model_addr + 11'd1;   // wraps like the device.
        end
    endtask

    task automatic read_data(input logic [2:0] page, input int count);
        logic acked;
        logic [7:0] b;
        int i;
        bus_start();
        send_byte(ctrl_byte(page, 1'b1), acked);
        expect_ack(acked, "read control byte");
        model_addr[10:8] = page;
        for (i = 0; i < count; i++)
        begin
            recv_byte(i < count - 1, b);       // nack on the last byte.
            got_byte = b;
            got_addr = model_addr;
            -> byte_received;
            model_addr = model_addr + 11'd1;
        end
        bus_stop();
    endtask

    // ******************************
    // test sequence
    // ******************************

    initial
    begin
        logic [31:0] rnd;
        logic [10:0] a;
        logic        acked;
        int          i;
        int          t;
        int          k;
        int          len;

        repeat (10) @(posedge sda);
        #2;
        rst = 1'b0;
        wait_clks(5);

        rnd = $random(seed);                   // single byte write and random read.
        a = rnd[10:0];
        wr_buf[0] = rnd[18:11];
        set_address(a);
        write_data(1);
        bus_stop();
        set_address(a);
        read_data(a[10:8], 1);

        for (i = 0; i < 12; i++)               // sequential write across a page.
        begin
            rnd = $random(seed);
            wr_buf[i] = rnd[7:0];
        end
        set_address(11'h1fa);
        write_data(12);
        bus_stop();
        set_address(11'h1fa);
        read_data(3'd1, 12);
        set_address(11'h200);                  // page 2 read back on its own.
        read_data(3'd2, 6);

        set_address(11'h1fb);                  // current address follows the last read.
        read_data(3'd1, 1);
        read_data(model_addr[10:8], 1);

        bus_start();                           // foreign device code.
        send_byte({4'b0110, 3'b001, 1'b0}, acked);
        checks++;
        if (acked)
        begin
            errors++;
            $display("ERROR at %0t: a foreign control byte was acknowledged", $time);
        end
        send_byte(8'hfa, acked);
        send_byte(~ref_mem[11'h1fa], acked);
        bus_stop();
        set_address(11'h1fa);
        read_data(3'd1, 1);

        for (i = 0; i < 2; i++)                // stop in the middle of a byte.
        begin
            rnd = $random(seed);
            wr_buf[i] = rnd[7:0];
        end
        set_address(11'h1fc);
        write_data(2);
        send_bits(~ref_mem[11'h1fe], 4);
        bus_stop();
        set_address(11'h1fc);
        read_data(3'd1, 3);

        for (t = 0; t < 20; t++)               // random writes and reads.
        begin
            rnd = $random(seed);
            if (wr_start.size() == 0 || rnd[0])
            begin
                len = int'(rnd[2:1]) + 1;
                a = rnd[13:3];
                for (i = 0; i < len; i++)
                begin
                    rnd = $random(seed);
                    wr_buf[i] = rnd[7:0];
                end
                set_address(a);
                write_data(len);
                bus_stop();
                wr_start.push_back(a);
                wr_len.push_back(len);
            end
            else
            begin
                k = int'(rnd[15:8]) % wr_start.size();
                a = wr_start[k];
                set_address(a);
                read_data(a[10:8], wr_len[k]);
            end
        end

        wait_clks(half_clks);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("Finished with no errors");
        end
        else
        begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+tests
hw/eeprom_pkg.sv
hw/i2c_byte_if.sv
hw/mem_port_if.sv
hw/i2c_bit_engine.sv
hw/eeprom_cmd_fsm.sv
hw/eeprom_array.sv
hw/eeprom_top.sv
tests/tb_eeprom_top.sv

/* run_sim.sh */
#!/bin/sh
set -e

# Build the testbench and the design with Verilator, then run it.
verilator --binary --timing -Wno-fatal -f files.f --top-module tb_eeprom_top
./obj_dir/Vtb_eeprom_top > sim.log 2>&1
cat sim.log

if grep -q "Finished with errors" sim.log
then
    exit 1
fi
exit 0
